// ==== design/alu.sv ====
`timescale 1ns/10ps

module alu import alu_pkg::*, cpu_pkg::*; (
	input  logic    clk,
	input  logic    rdy,
	input  alu_op_t op,
	input  logic    right,
	input  byte_t   ai,
	input  byte_t   bi,
	input  logic    ci,
	input  logic    bcd,	// BCD style carry for decimal add
	output byte_t   out,
	output logic    co,
	output logic    v,
	output logic    z,
	output logic    n,
	output logic    hc
);

	logic            ai7_q;	// Operand signs for overflow
	logic            bi7_q;
	logic [DATA_W:0] temp_logic;	// Bit 8 catches the bit shifted out right
	byte_t           temp_bi;
	logic [4:0]      temp_l;	// Low nibble sum with carry
	logic [4:0]      temp_h;
	logic [DATA_W:0] sum;
	logic            adder_ci;
	logic            hc9;
	logic            co9;
	logic            temp_hc;

	// No carry into the adder for logic ops and shifts right
	assign adder_ci = (right || op[3:2] == 2'b11) ? 1'b0 : ci;

	// Logic stage
	always_comb begin
		case (op[1:0])
		2'b00: temp_logic = {1'b0, ai | bi};
		2'b01: temp_logic = {1'b0, ai & bi};
		2'b10: temp_logic = {1'b0, ai ^ bi};
		2'b11: temp_logic = {1'b0, ai};
		endcase
		if (right)
			temp_logic = {ai[0], ci, ai[7:1]};	// ci enters at the top for ROR
	end

	// Second adder operand
	always_comb begin
		case (op[3:2])
		2'b00: temp_bi = bi;
		2'b01: temp_bi = ~bi;			// Subtract via ones complement
		2'b10: temp_bi = temp_logic[7:0];	// Doubling
		2'b11: temp_bi = '0;			// Logic result passes
		endcase
	end

	// Nibble value of ten or more in BCD add
	assign hc9     = bcd && (temp_l[3:1] >= 3'd5);
	assign co9     = bcd && (temp_h[3:1] >= 3'd5);
	assign temp_hc = temp_l[4] | hc9;

	// Two nibble adds so the half carry is visible
	always_comb begin
		temp_l = {1'b0, temp_logic[3:0]} + {1'b0, temp_bi[3:0]} + {4'b0, adder_ci};
		temp_h = temp_logic[8:4] + {1'b0, temp_bi[7:4]} + {4'b0, temp_hc};
	end

	assign sum = {temp_h, temp_l[3:0]};

	always_ff @(posedge clk) begin
		if (rdy) begin
			ai7_q <= ai[7];
			bi7_q <= temp_bi[7];
			out   <= sum[7:0];
			co    <= sum[8] | co9;
			n     <= sum[7];
			hc    <= temp_hc;
		end
	end

	// Overflow from the sign bits and carries
	assign v = ai7_q ^ bi7_q ^ co ^ n;
	assign z = ~|out;

	op_known: assert property (@(posedge clk) rdy |-> !$isunknown(op))
		else $error("alu op unknown while loading");

endmodule

// ==== design/alu_pkg.sv ====
package alu_pkg;

	// Width of the datapath
	localparam int DATA_W = 8;

	// op[3:2] picks the adder's second operand
	// op[1:0] picks the logic function
	typedef logic [3:0] alu_op_t;

	localparam alu_op_t ALU_ADD  = 4'b0011;	// ai + bi + ci
	localparam alu_op_t ALU_SUB  = 4'b0111;	// ai + ~bi + ci
	localparam alu_op_t ALU_DBL  = 4'b1011;	// ai + ai + ci, left shift
	localparam alu_op_t ALU_OR   = 4'b1100;	// ai | bi
	localparam alu_op_t ALU_AND  = 4'b1101;	// ai & bi
	localparam alu_op_t ALU_XOR  = 4'b1110;	// ai ^ bi
	localparam alu_op_t ALU_PASS = 4'b1111;	// ai, also the right shift base

endpackage

// ==== design/cpu_pkg.sv ====
package cpu_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [7:0] opcode_t;

	// Supported opcodes, 6502 values
	localparam opcode_t OP_ADC_IMM = 8'h69;
	localparam opcode_t OP_SBC_IMM = 8'he9;
	localparam opcode_t OP_AND_IMM = 8'h29;
	localparam opcode_t OP_ORA_IMM = 8'h09;
	localparam opcode_t OP_EOR_IMM = 8'h49;
	localparam opcode_t OP_CMP_IMM = 8'hc9;
	localparam opcode_t OP_CPX_IMM = 8'he0;
	localparam opcode_t OP_CPY_IMM = 8'hc0;
	localparam opcode_t OP_LDA_IMM = 8'ha9;
	localparam opcode_t OP_LDX_IMM = 8'ha2;
	localparam opcode_t OP_LDY_IMM = 8'ha0;
	localparam opcode_t OP_ASL_A   = 8'h0a;
	localparam opcode_t OP_LSR_A   = 8'h4a;
	localparam opcode_t OP_ROL_A   = 8'h2a;
	localparam opcode_t OP_ROR_A   = 8'h6a;
	localparam opcode_t OP_INX     = 8'he8;
	localparam opcode_t OP_INY     = 8'hc8;
	localparam opcode_t OP_DEX     = 8'hca;
	localparam opcode_t OP_DEY     = 8'h88;
	localparam opcode_t OP_TAX     = 8'haa;
	localparam opcode_t OP_TAY     = 8'ha8;
	localparam opcode_t OP_TXA     = 8'h8a;
	localparam opcode_t OP_TYA     = 8'h98;
	localparam opcode_t OP_CLC     = 8'h18;
	localparam opcode_t OP_SEC     = 8'h38;
	localparam opcode_t OP_CLD     = 8'hd8;
	localparam opcode_t OP_SED     = 8'hf8;
	localparam opcode_t OP_CLV     = 8'hb8;

	// Register select
	typedef logic [1:0] reg_sel_t;
	localparam reg_sel_t SEL_A    = 2'd0;
	localparam reg_sel_t SEL_X    = 2'd1;
	localparam reg_sel_t SEL_Y    = 2'd2;
	localparam reg_sel_t SEL_NONE = 2'd3;	// No register, reads as zero

	// Carry-in source for the ALU
	typedef logic [1:0] ci_mode_t;
	localparam ci_mode_t CI_ZERO  = 2'd0;
	localparam ci_mode_t CI_ONE   = 2'd1;
	localparam ci_mode_t CI_CARRY = 2'd2;	// Forwarded C flag

	// Status bit positions
	localparam int P_C = 0;
	localparam int P_Z = 1;
	localparam int P_D = 3;
	localparam int P_U = 5;		// Unused, reads as one
	localparam int P_V = 6;
	localparam int P_N = 7;

	localparam byte_t P_RESET = 8'h24;	// I and bit 5 set

	// Flag update masks by P position
	localparam byte_t F_NZ   = 8'h82;
	localparam byte_t F_NZC  = 8'h83;
	localparam byte_t F_NZCV = 8'hc3;

endpackage

// ==== design/decimal_adjust.sv ====
`timescale 1ns/10ps

module decimal_adjust import cpu_pkg::*; (
	input  byte_t bin,	// Registered ALU result
	input  logic  hc,	// Low nibble carry
	input  logic  co,	// High nibble carry
	input  logic  enable,
	input  logic  subtract,
	output byte_t result
);

	logic [3:0] lo;
	logic [3:0] hi;

	always_comb begin
		lo = bin[3:0];
		hi = bin[7:4];
		if (enable) begin
			if (!subtract) begin
				// Add: carried nibbles skip the six unused codes
				if (hc)
					lo = lo + 4'd6;
				if (co)
					hi = hi + 4'd6;
			end else begin
				// Subtract: clear carry means that nibble borrowed
				if (!hc)
					lo = lo - 4'd6;	// Same as adding ten
				if (!co)
					hi = hi - 4'd6;
			end
		end
	end

	assign result = {hi, lo};

endmodule

// ==== design/exec_unit.sv ====
`timescale 1ns/10ps

module exec_unit import alu_pkg::*, cpu_pkg::*; (
	input  logic    clk,
	input  logic    reset,
	input  logic    rdy,
	input  logic    issue,
	input  opcode_t opcode,
	input  byte_t   operand,
	output byte_t   a,
	output byte_t   x,
	output byte_t   y,
	output byte_t   p,
	output logic    done,
	output logic    illegal
);

	// Decode outputs
	alu_op_t  dec_alu_op;
	logic     dec_right;
	reg_sel_t dec_a_sel;
	logic     dec_use_operand;
	reg_sel_t dec_b_sel;
	ci_mode_t dec_ci_mode;
	reg_sel_t dec_dst;
	byte_t    dec_flag_mask;
	byte_t    dec_flag_set;
	byte_t    dec_flag_clr;
	logic     dec_decimal_op;
	logic     dec_subtract;
	logic     dec_legal;

	byte_t rdata_a;
	byte_t rdata_b;
	byte_t alu_ai;
	byte_t alu_bi;
	logic  alu_ci;
	logic  alu_bcd;
	logic  alu_en;
	logic  fwd_carry;
	logic  fwd_decimal;

	// Stage 1 state
	logic     s1_valid;
	reg_sel_t s1_dst;
	byte_t    s1_mask;
	byte_t    s1_set;
	byte_t    s1_clr;
	logic     s1_dec_en;	// D set and ADC or SBC
	logic     s1_subtract;

	byte_t alu_out;
	logic  alu_co;
	logic  alu_v;
	logic  alu_z;
	logic  alu_n;
	logic  alu_hc;
	byte_t wb_data;

	op_decode op_decode_inst (
		.opcode      (opcode),
		.alu_op      (dec_alu_op),
		.right       (dec_right),
		.a_sel       (dec_a_sel),
		.use_operand (dec_use_operand),
		.b_sel       (dec_b_sel),
		.ci_mode     (dec_ci_mode),
		.dst         (dec_dst),
		.flag_mask   (dec_flag_mask),
		.flag_set    (dec_flag_set),
		.flag_clr    (dec_flag_clr),
		.decimal_op  (dec_decimal_op),
		.subtract    (dec_subtract),
		.legal       (dec_legal)
	);

	assign alu_en = rdy && issue && dec_legal;	// Only real instructions load the ALU

	// Operand muxes
	assign alu_ai = (dec_a_sel == SEL_NONE) ? operand : rdata_a;
	assign alu_bi = dec_use_operand ? operand : rdata_b;

	// Carry-in from mode, using the forwarded C
	assign alu_ci = (dec_ci_mode == CI_CARRY) ? fwd_carry : (dec_ci_mode == CI_ONE);

	// BCD carry only for decimal add, subtract borrows stay binary
	assign alu_bcd = dec_decimal_op && !dec_subtract && fwd_decimal;

	alu alu_inst (
		.clk   (clk),
		.rdy   (alu_en),
		.op    (dec_alu_op),
		.right (dec_right),
		.ai    (alu_ai),
		.bi    (alu_bi),
		.ci    (alu_ci),
		.bcd   (alu_bcd),
		.out   (alu_out),
		.co    (alu_co),
		.v     (alu_v),
		.z     (alu_z),
		.n     (alu_n),
		.hc    (alu_hc)
	);

	// Control pipeline and pulses
	always_ff @(posedge clk) begin
		if (reset) begin
			s1_valid <= 1'b0;
			done     <= 1'b0;
			illegal  <= 1'b0;
		end else if (rdy) begin
			s1_valid <= issue && dec_legal;
			done     <= s1_valid;		// Writeback on this edge
			illegal  <= issue && !dec_legal;
		end else begin
			done    <= 1'b0;
			illegal <= 1'b0;
		end
	end

	// Stage 1 payload, qualified by s1_valid
	always_ff @(posedge clk) begin
		if (alu_en) begin
			s1_dst      <= dec_dst;
			s1_mask     <= dec_flag_mask;
			s1_set      <= dec_flag_set;
			s1_clr      <= dec_flag_clr;
			s1_dec_en   <= dec_decimal_op && fwd_decimal;
			s1_subtract <= dec_subtract;
		end
	end

	decimal_adjust decimal_adjust_inst (
		.bin      (alu_out),
		.hc       (alu_hc),
		.co       (alu_co),
		.enable   (s1_dec_en),
		.subtract (s1_subtract),
		.result   (wb_data)
	);

	reg_file reg_file_inst (
		.clk     (clk),
		.reset   (reset),
		.rdy     (rdy),
		.we      (s1_valid),
		.wsel    (s1_dst),
		.wdata   (wb_data),
		.rsel_a  (dec_a_sel),
		.rsel_b  (dec_b_sel),
		.rdata_a (rdata_a),
		.rdata_b (rdata_b),
		.a       (a),
		.x       (x),
		.y       (y)
	);

	// N, Z, V from the binary result, C from the ALU carry
	status_reg status_reg_inst (
		.clk     (clk),
		.reset   (reset),
		.rdy     (rdy),
		.we      (s1_valid),
		.mask    (s1_mask),
		.set     (s1_set),
		.clr     (s1_clr),
		.c_in    (alu_co),
		.z_in    (alu_z),
		.v_in    (alu_v),
		.n_in    (alu_n),
		.p       (p),
		.carry   (fwd_carry),
		.decimal (fwd_decimal)
	);

endmodule

// ==== design/op_decode.sv ====
`timescale 1ns/10ps

module op_decode import alu_pkg::*, cpu_pkg::*; (
	input  opcode_t  opcode,
	output alu_op_t  alu_op,
	output logic     right,
	output reg_sel_t a_sel,		// SEL_NONE puts the operand on A
	output logic     use_operand,	// Operand on B
	output reg_sel_t b_sel,
	output ci_mode_t ci_mode,
	output reg_sel_t dst,
	output byte_t    flag_mask,
	output byte_t    flag_set,
	output byte_t    flag_clr,
	output logic     decimal_op,	// ADC or SBC
	output logic     subtract,
	output logic     legal
);

	always_comb begin
		alu_op      = ALU_PASS;
		right       = 1'b0;
		a_sel       = SEL_A;
		use_operand = 1'b0;
		b_sel       = SEL_NONE;
		ci_mode     = CI_ZERO;
		dst         = SEL_NONE;
		flag_mask   = '0;
		flag_set    = '0;
		flag_clr    = '0;
		decimal_op  = 1'b0;
		subtract    = 1'b0;
		legal       = 1'b1;
		case (opcode)
		OP_ADC_IMM, OP_SBC_IMM: begin
			subtract    = (opcode == OP_SBC_IMM);
			alu_op      = subtract ? ALU_SUB : ALU_ADD;
			use_operand = 1'b1;
			ci_mode     = CI_CARRY;
			dst         = SEL_A;
			flag_mask   = F_NZCV;
			decimal_op  = 1'b1;
		end
		OP_AND_IMM, OP_ORA_IMM, OP_EOR_IMM: begin
			alu_op      = (opcode == OP_AND_IMM) ? ALU_AND :
				      (opcode == OP_ORA_IMM) ? ALU_OR : ALU_XOR;
			use_operand = 1'b1;
			dst         = SEL_A;
			flag_mask   = F_NZ;
		end
		OP_CMP_IMM, OP_CPX_IMM, OP_CPY_IMM: begin
			alu_op      = ALU_SUB;
			a_sel       = (opcode == OP_CMP_IMM) ? SEL_A :
				      (opcode == OP_CPX_IMM) ? SEL_X : SEL_Y;
			use_operand = 1'b1;
			ci_mode     = CI_ONE;		// No borrow in
			flag_mask   = F_NZC;		// Result itself is dropped
		end
		OP_LDA_IMM, OP_LDX_IMM, OP_LDY_IMM: begin
			a_sel     = SEL_NONE;		// Pass the operand
			dst       = (opcode == OP_LDA_IMM) ? SEL_A :
				    (opcode == OP_LDX_IMM) ? SEL_X : SEL_Y;
			flag_mask = F_NZ;
		end
		OP_ASL_A, OP_ROL_A: begin
			alu_op    = ALU_DBL;
			ci_mode   = (opcode == OP_ROL_A) ? CI_CARRY : CI_ZERO;
			dst       = SEL_A;
			flag_mask = F_NZC;
		end
		OP_LSR_A, OP_ROR_A: begin
			right     = 1'b1;
			ci_mode   = (opcode == OP_ROR_A) ? CI_CARRY : CI_ZERO;
			dst       = SEL_A;
			flag_mask = F_NZC;
		end
		OP_INX, OP_INY: begin
			alu_op    = ALU_ADD;
			a_sel     = (opcode == OP_INX) ? SEL_X : SEL_Y;
			ci_mode   = CI_ONE;		// x + 0 + 1
			dst       = a_sel;
			flag_mask = F_NZ;
		end
		OP_DEX, OP_DEY: begin
			alu_op    = ALU_SUB;
			a_sel     = (opcode == OP_DEX) ? SEL_X : SEL_Y;
			dst       = a_sel;		// x + ff + 0
			flag_mask = F_NZ;
		end
		OP_TAX, OP_TAY: begin
			dst       = (opcode == OP_TAX) ? SEL_X : SEL_Y;
			flag_mask = F_NZ;
		end
		OP_TXA, OP_TYA: begin
			a_sel     = (opcode == OP_TXA) ? SEL_X : SEL_Y;
			dst       = SEL_A;
			flag_mask = F_NZ;
		end
		OP_CLC: flag_clr[P_C] = 1'b1;
		OP_SEC: flag_set[P_C] = 1'b1;
		OP_CLD: flag_clr[P_D] = 1'b1;
		OP_SED: flag_set[P_D] = 1'b1;
		OP_CLV: flag_clr[P_V] = 1'b1;
		default: legal = 1'b0;
		endcase
	end

endmodule

// ==== design/reg_file.sv ====
`timescale 1ns/10ps

module reg_file import cpu_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  logic     rdy,
	input  logic     we,
	input  reg_sel_t wsel,
	input  byte_t    wdata,
	input  reg_sel_t rsel_a,
	input  reg_sel_t rsel_b,
	output byte_t    rdata_a,
	output byte_t    rdata_b,
	output byte_t    a,
	output byte_t    x,
	output byte_t    y
);

	byte_t a_q;
	byte_t x_q;
	byte_t y_q;

	// Read with bypass of the value being written back
	function automatic byte_t read_port(input reg_sel_t sel);
		byte_t val;
		case (sel)
		SEL_A:   val = a_q;
		SEL_X:   val = x_q;
		SEL_Y:   val = y_q;
		default: val = '0;
		endcase
		if (we && sel == wsel && sel != SEL_NONE)
			val = wdata;
		return val;
	endfunction

	always_ff @(posedge clk) begin
		if (reset) begin
			a_q <= '0;
			x_q <= '0;
			y_q <= '0;
		end else if (rdy && we) begin
			case (wsel)
			SEL_A:   a_q <= wdata;
			SEL_X:   x_q <= wdata;
			SEL_Y:   y_q <= wdata;
			default: ;		// Compares and flag ops write nothing
			endcase
		end
	end

	always_comb begin
		rdata_a = read_port(rsel_a);
		rdata_b = read_port(rsel_b);
	end

	assign a = a_q;
	assign x = x_q;
	assign y = y_q;

endmodule

// ==== design/status_reg.sv ====
`timescale 1ns/10ps

module status_reg import cpu_pkg::*; (
	input  logic  clk,
	input  logic  reset,
	input  logic  rdy,
	input  logic  we,
	input  byte_t mask,	// Flags taken from the ALU
	input  byte_t set,
	input  byte_t clr,
	input  logic  c_in,
	input  logic  z_in,
	input  logic  v_in,
	input  logic  n_in,
	output byte_t p,
	output logic  carry,	// Forwarded C
	output logic  decimal	// Forwarded D
);

	byte_t p_q;
	byte_t flags_in;
	byte_t p_next;

	always_comb begin
		flags_in      = '0;
		flags_in[P_C] = c_in;
		flags_in[P_Z] = z_in;
		flags_in[P_V] = v_in;
		flags_in[P_N] = n_in;

		p_next = (p_q & ~mask) | (flags_in & mask);	// Masked ALU flags
		p_next = (p_next | set) & ~clr;			// Then flag ops
	end

	always_ff @(posedge clk) begin
		if (reset)
			p_q <= P_RESET;
		else if (rdy && we)
			p_q <= p_next;
	end

	// Next instruction sees the flag being written
	assign carry   = we ? p_next[P_C] : p_q[P_C];
	assign decimal = we ? p_next[P_D] : p_q[P_D];
	assign p       = p_q;

	unused_bit_set: assert property (@(posedge clk) disable iff (reset) p_q[P_U])
		else $error("status bit 5 cleared, p = %h", p_q);

endmodule

// ==== exec_unit.f ====
design/alu_pkg.sv
design/cpu_pkg.sv
design/alu.sv
design/decimal_adjust.sv
design/op_decode.sv
design/reg_file.sv
design/status_reg.sv
design/exec_unit.sv
sim/exec_unit_tb.sv

// ==== sim/exec_unit_tb.sv ====
`timescale 1ns/10ps

module exec_unit_tb import cpu_pkg::*; ();

	localparam int N_LOAD       = 4;	// Eight instructions each
	localparam int N_ARITH      = 16;	// Six each
	localparam int N_LOGIC      = 8;	// Nine each
	localparam int N_BCD        = 12;	// Six each
	localparam int N_B2B        = 4;	// Fifteen each
	localparam int NUM_INSTR    = N_LOAD * 8 + N_ARITH * 6 + N_LOGIC * 9 + N_BCD * 6 + 5
				      + N_B2B * 15 + 3;
	localparam int WATCHDOG_CYC = NUM_INSTR * 4 + 200;
	localparam int DONE_LIMIT   = 8;	// Cycles to wait for done
	localparam int STALL_CYCLES = 6;
	localparam opcode_t OP_BAD  = 8'h02;	// Not in the subset

	logic    clk;
	logic    reset;
	logic    rdy;
	logic    issue;
	opcode_t opcode;
	byte_t   operand;
	byte_t   a;
	byte_t   x;
	byte_t   y;
	byte_t   p;
	logic    done;
	logic    illegal;

	// Reference model state
	byte_t       m_a;
	byte_t       m_x;
	byte_t       m_y;
	byte_t       m_p;
	logic [31:0] exp_q[$];	// {a, x, y, p} per issued instruction
	logic [31:0] seed = 32'hf769;
	int          errors = 0;
	int          checks = 0;

	exec_unit exec_unit_inst (
		.clk     (clk),
		.reset   (reset),
		.rdy     (rdy),
		.issue   (issue),
		.opcode  (opcode),
		.operand (operand),
		.a       (a),
		.x       (x),
		.y       (y),
		.p       (p),
		.done    (done),
		.illegal (illegal)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic byte_t rand_byte();
		seed = seed * 32'd1664525 + 32'd1013904223;	// LCG step
		return seed[23:16];
	endfunction

	function automatic byte_t rand_bcd();
		byte_t hi;
		byte_t lo;
		hi = rand_byte();
		lo = rand_byte();
		return {4'(hi % 10), 4'(lo % 10)};
	endfunction

	function automatic opcode_t carry_op();	// Random SEC or CLC
		byte_t r;
		r = rand_byte();
		return r[0] ? OP_SEC : OP_CLC;
	endfunction

	function automatic int bcd_value(input byte_t b);
		return 10 * int'(b[7:4]) + int'(b[3:0]);
	endfunction

	function automatic byte_t to_bcd(input int v);
		return {4'(v / 10), 4'(v % 10)};
	endfunction

	task automatic check_byte(input string name, input byte_t got, input byte_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error %s: got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_p(input byte_t got, input byte_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error p: got %h expected %h at %0t", got, exp, $time);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error %s: got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic set_nz(input byte_t v);
		m_p[P_N] = v[7];
		m_p[P_Z] = (v == 8'h00);
	endtask

	// Binary add, SBC passes the inverted operand
	task automatic add_flags(input byte_t l, input byte_t r, input logic cin, output byte_t res);
		logic [8:0] sum;
		sum = {1'b0, l} + {1'b0, r} + {8'b0, cin};
		res = sum[7:0];
		m_p[P_C] = sum[8];
		m_p[P_V] = (l[7] == r[7]) && (res[7] != l[7]);	// Sign changed on like signs
		set_nz(res);
	endtask

	task automatic decimal_adc(input byte_t opd);
		int    lo;
		int    hi;
		int    total;
		byte_t bin;
		logic  cout;
		// Nibble sums, carry forced at ten
		lo    = int'(m_a[3:0]) + int'(opd[3:0]) + int'(m_p[P_C]);
		hi    = int'(m_a[7:4]) + int'(opd[7:4]) + ((lo >= 10) ? 1 : 0);
		cout  = (hi >= 10);
		bin   = {4'(hi), 4'(lo)};
		total = bcd_value(m_a) + bcd_value(opd) + int'(m_p[P_C]);
		m_p[P_C] = (total >= 100);
		m_p[P_V] = m_a[7] ^ opd[7] ^ bin[7] ^ cout;	// Carry into bit 7 vs out
		set_nz(bin);
		m_a = to_bcd(total % 100);
	endtask

	task automatic decimal_sbc(input byte_t opd);
		int    diff;
		byte_t res;
		diff = bcd_value(m_a) - bcd_value(opd) - (1 - int'(m_p[P_C]));
		add_flags(m_a, ~opd, m_p[P_C], res);	// Flags stay binary
		m_a = to_bcd((diff + 100) % 100);
	endtask

	task automatic compare(input byte_t r, input byte_t v);
		m_p[P_C] = (r >= v);
		set_nz(r - v);
	endtask

	task automatic model_exec(input opcode_t opc, input byte_t opd);
		byte_t res;
		logic  c;
		c = m_p[P_C];	// Prior carry for rotates and adds
		case (opc)
		OP_ADC_IMM: begin
			if (m_p[P_D]) begin
				decimal_adc(opd);
			end else begin
				add_flags(m_a, opd, c, res);
				m_a = res;
			end
		end
		OP_SBC_IMM: begin
			if (m_p[P_D]) begin
				decimal_sbc(opd);
			end else begin
				add_flags(m_a, ~opd, c, res);
				m_a = res;
			end
		end
		OP_AND_IMM: m_a = m_a & opd;
		OP_ORA_IMM: m_a = m_a | opd;
		OP_EOR_IMM: m_a = m_a ^ opd;
		OP_CMP_IMM: compare(m_a, opd);
		OP_CPX_IMM: compare(m_x, opd);
		OP_CPY_IMM: compare(m_y, opd);
		OP_LDA_IMM: m_a = opd;
		OP_LDX_IMM: m_x = opd;
		OP_LDY_IMM: m_y = opd;
		OP_ASL_A, OP_ROL_A: begin
			m_p[P_C] = m_a[7];
			m_a = {m_a[6:0], (opc == OP_ROL_A) ? c : 1'b0};
		end
		OP_LSR_A, OP_ROR_A: begin
			m_p[P_C] = m_a[0];
			m_a = {(opc == OP_ROR_A) ? c : 1'b0, m_a[7:1]};
		end
		OP_INX: m_x = m_x + 8'd1;
		OP_INY: m_y = m_y + 8'd1;
		OP_DEX: m_x = m_x - 8'd1;
		OP_DEY: m_y = m_y - 8'd1;
		OP_TAX: m_x = m_a;
		OP_TAY: m_y = m_a;
		OP_TXA: m_a = m_x;
		OP_TYA: m_a = m_y;
		OP_CLC: m_p[P_C] = 1'b0;
		OP_SEC: m_p[P_C] = 1'b1;
		OP_CLD: m_p[P_D] = 1'b0;
		OP_SED: m_p[P_D] = 1'b1;
		OP_CLV: m_p[P_V] = 1'b0;
		default: ;
		endcase
		// N and Z follow the written register
		case (opc)
		OP_AND_IMM, OP_ORA_IMM, OP_EOR_IMM, OP_LDA_IMM, OP_TXA, OP_TYA,
		OP_ASL_A, OP_ROL_A, OP_LSR_A, OP_ROR_A: set_nz(m_a);
		OP_LDX_IMM, OP_INX, OP_DEX, OP_TAX: set_nz(m_x);
		OP_LDY_IMM, OP_INY, OP_DEY, OP_TAY: set_nz(m_y);
		default: ;
		endcase
	endtask

	// Compare the architectural state when done pulses
	task automatic collect_done();
		logic [31:0] st;
		check_bit("illegal", illegal, 1'b0);
		if (done) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("done pulsed with no instruction in flight at %0t", $time);
			end else begin
				st = exp_q.pop_front();
				check_byte("a", a, st[31:24]);
				check_byte("x", x, st[23:16]);
				check_byte("y", y, st[15:8]);
				check_p(p, st[7:0]);
			end
		end
	endtask

	// Called at a falling edge, returns one cycle later
	task automatic issue_op(input opcode_t opc, input byte_t opd);
		model_exec(opc, opd);
		exp_q.push_back({m_a, m_x, m_y, m_p});
		opcode  = opc;
		operand = opd;
		issue   = 1'b1;
		@(negedge clk);
		issue = 1'b0;
		collect_done();
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		while (exp_q.size() != 0 && waited < DONE_LIMIT) begin
			@(negedge clk);
			collect_done();
			waited++;
		end
		if (exp_q.size() != 0) begin
			errors++;
			$display("no done seen for %0d issued instruction(s) at %0t", exp_q.size(), $time);
			exp_q.delete();
		end
	endtask

	task automatic run_op(input opcode_t opc, input byte_t opd);
		issue_op(opc, opd);
		drain();
	endtask

	task automatic check_state_held(input byte_t sa, input byte_t sx, input byte_t sy,
					input byte_t sp);
		check_byte("a", a, sa);
		check_byte("x", x, sx);
		check_byte("y", y, sy);
		check_p(p, sp);
	endtask

	task automatic test_load_transfer();
		check_state_held(8'h00, 8'h00, 8'h00, P_RESET);	// Out of reset
		for (int i = 0; i < N_LOAD; i++) begin
			run_op(OP_LDA_IMM, (i == 0) ? 8'h00 : rand_byte());	// Z on first pass
			run_op(OP_TAX, 8'h00);
			run_op(OP_LDY_IMM, (i == 0) ? 8'h80 : rand_byte());	// N on first pass
			run_op(OP_TYA, 8'h00);
			run_op(OP_LDX_IMM, rand_byte());
			run_op(OP_TXA, 8'h00);
			run_op(OP_LDA_IMM, rand_byte());
			run_op(OP_TAY, 8'h00);
		end
	endtask

	task automatic test_binary_arith();
		for (int i = 0; i < N_ARITH; i++) begin
			run_op(OP_LDA_IMM, rand_byte());
			run_op(carry_op(), 8'h00);
			run_op(OP_ADC_IMM, rand_byte());
			run_op(OP_LDA_IMM, rand_byte());
			run_op(carry_op(), 8'h00);
			run_op(OP_SBC_IMM, rand_byte());
		end
	endtask

	task automatic test_logic_shift();
		for (int i = 0; i < N_LOGIC; i++) begin
			run_op(OP_LDA_IMM, rand_byte());
			run_op(OP_AND_IMM, rand_byte());
			run_op(OP_ORA_IMM, rand_byte());
			run_op(OP_EOR_IMM, rand_byte());
			run_op(OP_ASL_A, 8'h00);
			run_op(carry_op(), 8'h00);
			run_op(OP_ROL_A, 8'h00);
			run_op(OP_LSR_A, 8'h00);
			run_op(OP_ROR_A, 8'h00);	// Carry left by LSR
		end
	endtask

	task automatic test_decimal();
		run_op(OP_SED, 8'h00);
		for (int i = 0; i < N_BCD; i++) begin
			run_op(OP_LDA_IMM, rand_bcd());
			run_op(carry_op(), 8'h00);
			run_op(OP_ADC_IMM, rand_bcd());
			run_op(OP_LDA_IMM, rand_bcd());
			run_op(carry_op(), 8'h00);
			run_op(OP_SBC_IMM, rand_bcd());
		end
		run_op(OP_CLD, 8'h00);
		run_op(OP_LDA_IMM, 8'h09);
		run_op(OP_CLC, 8'h00);
		run_op(OP_ADC_IMM, 8'h01);
		check_byte("a", a, 8'h0a);	// Binary again after CLD
	endtask

	task automatic test_back_to_back();
		for (int i = 0; i < N_B2B; i++) begin
			run_op(OP_LDX_IMM, (i == 0) ? 8'hff : rand_byte());	// INX wraps
			run_op(OP_LDY_IMM, (i == 0) ? 8'h00 : rand_byte());	// DEY wraps
			run_op(OP_LDA_IMM, rand_byte());
			issue_op(OP_CMP_IMM, rand_byte());
			issue_op(OP_ADC_IMM, rand_byte());	// Carry straight from CMP
			issue_op(OP_ROL_A, 8'h00);
			issue_op(OP_INX, 8'h00);
			issue_op(OP_CPX_IMM, rand_byte());	// X from INX in flight
			issue_op(OP_INY, 8'h00);
			issue_op(OP_DEX, 8'h00);
			issue_op(OP_CPY_IMM, rand_byte());
			issue_op(OP_DEY, 8'h00);
			issue_op(OP_DEY, 8'h00);
			issue_op(OP_CMP_IMM, m_a);		// Equal, sets Z and C
			issue_op(OP_INX, 8'h00);
			drain();
		end
	endtask

	task automatic test_stall_illegal();
		byte_t sa;
		byte_t sx;
		byte_t sy;
		byte_t sp;
		run_op(OP_LDA_IMM, rand_byte());
		sa = m_a;
		sx = m_x;
		sy = m_y;
		sp = m_p;
		issue_op(OP_LDX_IMM, rand_byte());
		rdy = 1'b0;	// LDX now waits in stage 1
		repeat (STALL_CYCLES) begin
			@(negedge clk);
			check_bit("done", done, 1'b0);
			check_state_held(sa, sx, sy, sp);
		end
		rdy = 1'b1;
		drain();
		sx = m_x;
		sp = m_p;
		opcode  = OP_BAD;
		operand = rand_byte();
		issue   = 1'b1;
		@(negedge clk);
		issue = 1'b0;
		check_bit("illegal", illegal, 1'b1);
		repeat (4) begin
			@(negedge clk);
			check_bit("done", done, 1'b0);
			check_bit("illegal", illegal, 1'b0);	// One cycle pulse only
			check_state_held(sa, sx, sy, sp);
		end
	endtask

	initial begin
		reset   = 1'b1;
		rdy     = 1'b1;
		issue   = 1'b0;
		opcode  = OP_LDA_IMM;
		operand = 8'h00;
		m_a     = 8'h00;
		m_x     = 8'h00;
		m_y     = 8'h00;
		m_p     = P_RESET;
		repeat (16) @(negedge clk);
		reset = 1'b0;
		test_load_transfer();
		test_binary_arith();
		test_logic_shift();
		test_decimal();
		test_back_to_back();
		test_stall_illegal();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

	// Ends a hung run
	initial begin
		repeat (WATCHDOG_CYC) @(posedge clk);
		$display("watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYC);
		$display("Result: FAILED");
		$finish;
	end

endmodule
